/* per_pkg.sv */
// APB offsets are 5-bit byte addresses; only the 8 word-aligned offsets exist, the rest error
package per_pkg;

  localparam int addr_w = 5;
  localparam int data_w = 8;

  // Register offsets
  localparam int reg_pa   = 'h00;
  localparam int reg_pb   = 'h04;
  localparam int reg_mb   = 'h08;
  localparam int reg_mk   = 'h0C;
  localparam int reg_tm0  = 'h10;
  localparam int reg_tm1  = 'h14;
  localparam int reg_ctrl = 'h18;
  localparam int reg_pend = 'h1C;

  // Bit positions inside CTRL and MK
  localparam int ctrl_ie      = 0;
  localparam int ctrl_restart = 1;
  localparam int mk_int2_pol  = 5;

  // Timer reload and prescaler widths
  localparam int tm_w    = 12;
  localparam int presc_w = 3;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [addr_w-1:0] paddr;
    logic [data_w-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [data_w-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

endpackage

/* irq_pkg.sv */
// Four sources only; index order is priority order with index 0 highest, no serial or soft vector
package irq_pkg;

  localparam int n_irq = 4;

  // Source indices
  localparam int irq_int0 = 0;
  localparam int irq_intt = 1;
  localparam int irq_int1 = 2;
  localparam int irq_int2 = 3;

  // Vector bytes presented with a request
  localparam int vec_w = 8;
  localparam logic [vec_w-1:0] vec_int0 = 8'h04;
  localparam logic [vec_w-1:0] vec_intt = 8'h08;
  localparam logic [vec_w-1:0] vec_int1 = 8'h10;
  localparam logic [vec_w-1:0] vec_int2 = 8'h20;

  // INT1/INT2 sampling, one tick every smp_div cycles
  localparam int smp_div   = 12;
  localparam int smp_cnt_w = $clog2(smp_div);
  localparam int flt_depth = 4;

  // Oldest sample in the MSB
  localparam logic [flt_depth-1:0] flt_pattern = 4'b0111;

  typedef logic [n_irq-1:0] irq_mask_t;

  typedef struct packed {
    logic             req;
    logic [vec_w-1:0] vector;
  } irq_req_t;

endpackage

/* per_regs.sv */
// Zero-wait APB slave; writes land at the access-phase edge, read data is combinational from paddr
`timescale 1ns/1ps

module per_regs (
  input  logic                       CLK,
  input  logic                       reset,
  input  per_pkg::apb_req_t          apb_req,
  output per_pkg::apb_rsp_t          apb_rsp,
  input  logic [per_pkg::data_w-1:0] pb_in,
  output logic [per_pkg::data_w-1:0] pa_out,
  output logic [per_pkg::data_w-1:0] pb_out,
  output logic [per_pkg::data_w-1:0] pb_oe,
  input  irq_pkg::irq_mask_t         pending,
  output irq_pkg::irq_mask_t         enable,
  output logic                       int2_rise,
  output logic [per_pkg::tm_w-1:0]   tm_reload,
  output logic                       timer_restart,
  output irq_pkg::irq_mask_t         host_clear
);

  logic [per_pkg::data_w-1:0] pa_q;
  logic [per_pkg::data_w-1:0] pb_q;
  logic [per_pkg::data_w-1:0] mb_q;
  logic [per_pkg::data_w-1:0] mk_q;
  logic [per_pkg::tm_w-1:0]   tm_q;
  logic                       ie_q;
  logic                       access;
  logic                       wr;
  logic                       hit;
  logic [per_pkg::data_w-1:0] pb_rd;
  logic [per_pkg::data_w-1:0] rdata;

  assign access = apb_req.psel & apb_req.penable;
  assign wr     = access & apb_req.pwrite;

  ////////////////////////////////////////
  // Register writes

  always_ff @(posedge CLK) begin
    if (reset) begin
      pa_q <= '0;
      pb_q <= '0;
      mb_q <= '1;
      mk_q <= '1;
      tm_q <= '1;
      ie_q <= 1'b0;
    end else if (wr) begin
      case (apb_req.paddr)
        per_pkg::reg_pa:   pa_q <= apb_req.pwdata;
        per_pkg::reg_pb:   pb_q <= apb_req.pwdata;
        per_pkg::reg_mb:   mb_q <= apb_req.pwdata;
        per_pkg::reg_mk:   mk_q <= apb_req.pwdata;
        per_pkg::reg_tm0:  tm_q[per_pkg::data_w-1:0] <= apb_req.pwdata;
        per_pkg::reg_tm1:
          tm_q[per_pkg::tm_w-1:per_pkg::data_w] <=
            apb_req.pwdata[per_pkg::tm_w-per_pkg::data_w-1:0];
        per_pkg::reg_ctrl: ie_q <= apb_req.pwdata[per_pkg::ctrl_ie];
        default: ;
      endcase
    end
  end

  // MB bit set means input, so the pin wins there
  assign pb_rd = (pb_in & mb_q) | (pb_q & ~mb_q);

  ////////////////////////////////////////
  // Read mux and error decode

  always_comb begin
    rdata = '0;
    hit   = 1'b1;
    case (apb_req.paddr)
      per_pkg::reg_pa:   rdata = pa_q;
      per_pkg::reg_pb:   rdata = pb_rd;
      per_pkg::reg_mb:   rdata = mb_q;
      per_pkg::reg_mk:   rdata = mk_q;
      per_pkg::reg_tm0:  rdata = tm_q[per_pkg::data_w-1:0];
      per_pkg::reg_tm1:
        rdata[per_pkg::tm_w-per_pkg::data_w-1:0] = tm_q[per_pkg::tm_w-1:per_pkg::data_w];
      per_pkg::reg_ctrl: rdata[per_pkg::ctrl_ie] = ie_q;
      per_pkg::reg_pend: rdata[irq_pkg::n_irq-1:0] = pending;
      default:           hit = 1'b0;
    endcase
  end

  assign apb_rsp.prdata  = rdata;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access & ~hit;

  ////////////////////////////////////////
  // Outputs to the rest of the block

  assign pa_out = pa_q;
  assign pb_out = pb_q;
  assign pb_oe  = ~mb_q;

  // Set MK bit masks its source
  assign enable    = {irq_pkg::n_irq{ie_q}} & ~mk_q[irq_pkg::n_irq-1:0];
  assign int2_rise = mk_q[per_pkg::mk_int2_pol];
  assign tm_reload = tm_q;

  // Restart bit is write-only and self-clearing
  assign timer_restart = wr & (apb_req.paddr == per_pkg::reg_ctrl) &
                         apb_req.pwdata[per_pkg::ctrl_restart];

  assign host_clear = (wr && apb_req.paddr == per_pkg::reg_pend) ?
                      apb_req.pwdata[irq_pkg::n_irq-1:0] : '0;

  // Access phase only after a setup phase
  a_apb_setup : assert property (@(posedge CLK) disable iff (reset)
    $rose(apb_req.penable) |-> $past(apb_req.psel))
    else $error("penable rose without a setup phase");

endmodule

/* irq_sampler.sv */
// INT1/INT2 need one low then three high samples at the /12 tick; INT0 is level-held, not filtered
`timescale 1ns/1ps

module irq_sampler (
  input  logic               CLK,
  input  logic               reset,
  input  logic               int0,
  input  logic               int1,
  input  logic               int2,
  input  logic               int2_rise,
  output irq_pkg::irq_mask_t set,
  output logic               int0_low
);

  logic [irq_pkg::smp_cnt_w-1:0] smp_cnt;
  logic                          tick;
  logic [irq_pkg::flt_depth-1:0] int1_sh;
  logic [irq_pkg::flt_depth-1:0] int2_sh;
  logic                          int2_lvl;
  logic                          int0_q;
  logic                          int0_d;

  assign tick = (smp_cnt == irq_pkg::smp_div - 1);

  // INT2 polarity, low when inverted
  assign int2_lvl = int2 ^ ~int2_rise;

  always_ff @(posedge CLK) begin
    if (reset) begin
      smp_cnt <= '0;
      int1_sh <= '0;
      int2_sh <= '0;
      int0_q  <= 1'b0;
      int0_d  <= 1'b0;
    end else begin
      int0_q <= int0;
      int0_d <= int0_q;
      if (tick) begin
        smp_cnt <= '0;
        int1_sh <= {int1_sh[irq_pkg::flt_depth-2:0], int1};
        int2_sh <= {int2_sh[irq_pkg::flt_depth-2:0], int2_lvl};
      end else begin
        smp_cnt <= smp_cnt + 1'b1;
      end
    end
  end

  // Pattern is checked on the tick, against samples already taken
  always_comb begin
    set = '0;
    set[irq_pkg::irq_int0] = int0_q & ~int0_d;
    set[irq_pkg::irq_int1] = tick & (int1_sh == irq_pkg::flt_pattern);
    set[irq_pkg::irq_int2] = tick & (int2_sh == irq_pkg::flt_pattern);
  end

  assign int0_low = ~int0_q;

endmodule

/* irq_pending.sv */
// A set in the same cycle as any clear wins; INT0 pending drops as soon as INT0 reads low
`timescale 1ns/1ps

module irq_pending (
  input  logic               CLK,
  input  logic               reset,
  input  irq_pkg::irq_mask_t set,
  input  logic               int0_low,
  input  irq_pkg::irq_mask_t ack_clear,
  input  irq_pkg::irq_mask_t host_clear,
  output irq_pkg::irq_mask_t pending
);

  irq_pkg::irq_mask_t release_mask;
  irq_pkg::irq_mask_t clear;

  // INT0 is level style, released by the pin
  always_comb begin
    release_mask = '0;
    release_mask[irq_pkg::irq_int0] = int0_low;
  end

  assign clear = ack_clear | host_clear | release_mask;

  always_ff @(posedge CLK) begin
    if (reset) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~clear) | set;
    end
  end

  // Arbiter may only acknowledge what is still pending here
  a_ack_pending : assert property (@(posedge CLK) disable iff (reset)
    (ack_clear & ~pending) == '0)
    else $error("acknowledge of a source that is not pending");

endmodule

/* irq_arbiter.sv */
// Request is frozen until acknowledged, so a later higher-priority source waits its turn
`timescale 1ns/1ps

module irq_arbiter (
  input  logic               CLK,
  input  logic               reset,
  input  irq_pkg::irq_mask_t pending,
  input  irq_pkg::irq_mask_t enable,
  input  logic               irq_ack,
  output irq_pkg::irq_req_t  irq,
  output irq_pkg::irq_mask_t ack_clear
);

  irq_pkg::irq_mask_t             latched;
  irq_pkg::irq_mask_t             grant;
  logic [irq_pkg::vec_w-1:0]      vector;
  logic                           req;
  logic                           done;

  assign req  = |latched;
  assign done = req & irq_ack;

  always_ff @(posedge CLK) begin
    if (reset) begin
      latched <= '0;
    end else if (!req) begin
      latched <= pending & enable;
    end else if (done) begin
      latched <= '0;
    end
  end

  // Lowest index wins
  always_comb begin
    grant = '0;
    for (int i = irq_pkg::n_irq - 1; i >= 0; i--) begin
      if (latched[i]) begin
        grant    = '0;
        grant[i] = 1'b1;
      end
    end
  end

  always_comb begin
    vector = '0;
    case (1'b1)
      grant[irq_pkg::irq_int0]: vector = irq_pkg::vec_int0;
      grant[irq_pkg::irq_intt]: vector = irq_pkg::vec_intt;
      grant[irq_pkg::irq_int1]: vector = irq_pkg::vec_int1;
      grant[irq_pkg::irq_int2]: vector = irq_pkg::vec_int2;
      default: ;
    endcase
  end

  assign irq.req    = req;
  assign irq.vector = vector;
  assign ack_clear  = done ? grant : '0;

  // Request, grant and vector hold until the acknowledge
  a_req_hold : assert property (@(posedge CLK) disable iff (reset)
    req && !irq_ack |=> req && $stable(grant) && $stable(vector))
    else $error("request changed while waiting for acknowledge");

endmodule

/* event_timer.sv */
// Counts CLK cycles directly through a /8 prescaler; no timer output pin, no flip-flop
`timescale 1ns/1ps

module event_timer (
  input  logic                     CLK,
  input  logic                     reset,
  input  logic [per_pkg::tm_w-1:0] tm_reload,
  input  logic                     restart,
  output logic                     underflow
);

  // Low presc_w bits act as the prescaler
  logic [per_pkg::tm_w+per_pkg::presc_w-1:0] count;
  logic [per_pkg::tm_w+per_pkg::presc_w-1:0] reload_val;

  assign reload_val = {tm_reload, {per_pkg::presc_w{1'b1}}};

  assign underflow = (count == '0);

  always_ff @(posedge CLK) begin
    if (reset) begin
      count <= '1;
    end else if (underflow | restart) begin
      count <= reload_val;
    end else begin
      count <= count - 1'b1;
    end
  end

  // Period is (reload + 1) * 8 cycles
  a_reload_form : assert property (@(posedge CLK) disable iff (reset)
    underflow |=> count == $past(reload_val))
    else $error("timer count did not reload after underflow");

endmodule

/* per_top.sv */
// Interrupts leave through irq.req and irq_ack only; the host owns all registers through APB
`timescale 1ns/1ps

module per_top (
  input  logic                       CLK,
  input  logic                       reset,
  input  per_pkg::apb_req_t          apb_req,
  output per_pkg::apb_rsp_t          apb_rsp,
  input  logic [per_pkg::data_w-1:0] pb_in,
  output logic [per_pkg::data_w-1:0] pa_out,
  output logic [per_pkg::data_w-1:0] pb_out,
  output logic [per_pkg::data_w-1:0] pb_oe,
  input  logic                       int0,
  input  logic                       int1,
  input  logic                       int2,
  input  logic                       irq_ack,
  output irq_pkg::irq_req_t          irq
);

  irq_pkg::irq_mask_t         enable;
  irq_pkg::irq_mask_t         pending;
  irq_pkg::irq_mask_t         host_clear;
  irq_pkg::irq_mask_t         ack_clear;
  irq_pkg::irq_mask_t         smp_set;
  irq_pkg::irq_mask_t         set_mask;
  logic                       int2_rise;
  logic                       int0_low;
  logic                       timer_restart;
  logic                       underflow;
  logic [per_pkg::tm_w-1:0]   tm_reload;

  ////////////////////////////////////////
  // Register block and timer

  per_regs i_regs (
    .CLK           (CLK),
    .reset         (reset),
    .apb_req       (apb_req),
    .apb_rsp       (apb_rsp),
    .pb_in         (pb_in),
    .pa_out        (pa_out),
    .pb_out        (pb_out),
    .pb_oe         (pb_oe),
    .pending       (pending),
    .enable        (enable),
    .int2_rise     (int2_rise),
    .tm_reload     (tm_reload),
    .timer_restart (timer_restart),
    .host_clear    (host_clear)
  );

  event_timer i_timer (
    .CLK       (CLK),
    .reset     (reset),
    .tm_reload (tm_reload),
    .restart   (timer_restart),
    .underflow (underflow)
  );

  ////////////////////////////////////////
  // Interrupt path

  irq_sampler i_sampler (
    .CLK       (CLK),
    .reset     (reset),
    .int0      (int0),
    .int1      (int1),
    .int2      (int2),
    .int2_rise (int2_rise),
    .set       (smp_set),
    .int0_low  (int0_low)
  );

  // Timer underflow is the INTT set event
  assign set_mask = smp_set | (irq_pkg::irq_mask_t'(underflow) << irq_pkg::irq_intt);

  irq_pending i_pending (
    .CLK        (CLK),
    .reset      (reset),
    .set        (set_mask),
    .int0_low   (int0_low),
    .ack_clear  (ack_clear),
    .host_clear (host_clear),
    .pending    (pending)
  );

  irq_arbiter i_arbiter (
    .CLK       (CLK),
    .reset     (reset),
    .pending   (pending),
    .enable    (enable),
    .irq_ack   (irq_ack),
    .irq       (irq),
    .ack_clear (ack_clear)
  );

endmodule

/* tb_per_top.sv */
// Single CLK domain, zero-wait APB host; INT2 idles low when rising and high when falling
`timescale 1ns/1ps

module tb_per_top;

  localparam int clk_period  = 8;
  localparam int tick_cycles = 12;

  // Cycle budgets per test that the watchdog sums
  localparam int len_regs   = 600;
  localparam int len_portb  = 300;
  localparam int len_timer  = 500;
  localparam int len_filter = 1000;
  localparam int len_prio   = 2400;
  localparam int len_margin = 2000;

  logic              CLK;
  logic              reset;
  per_pkg::apb_req_t apb_req;
  per_pkg::apb_rsp_t apb_rsp;
  logic [7:0]        pb_in;
  logic [7:0]        pa_out;
  logic [7:0]        pb_out;
  logic [7:0]        pb_oe;
  logic              int0;
  logic              int1;
  logic              int2;
  logic              irq_ack;
  irq_pkg::irq_req_t irq;

  int          errors;
  int          test_errors;
  int          tests_run;
  int          checks;
  int unsigned cyc;
  logic [7:0]  rd_data;
  logic        rd_err;

  // Reference model state
  logic [7:0]  m_pa;
  logic [7:0]  m_pb;
  logic [7:0]  m_mb;
  logic [7:0]  m_mk;
  logic [11:0] m_tm;
  logic        m_ie;
  logic [3:0]  m_pend;

  per_top i_per_top (
    .CLK     (CLK),
    .reset   (reset),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .pb_in   (pb_in),
    .pa_out  (pa_out),
    .pb_out  (pb_out),
    .pb_oe   (pb_oe),
    .int0    (int0),
    .int1    (int1),
    .int2    (int2),
    .irq_ack (irq_ack),
    .irq     (irq)
  );

  initial begin
    CLK = 1'b0;
    forever #(clk_period / 2) CLK = ~CLK;
  end

  always @(posedge CLK) cyc <= cyc + 1;

  initial begin
    #((len_regs + len_portb + len_timer + len_filter + len_prio + len_margin) * clk_period);
    $display("Timeout: the tests did not finish within their cycle budget");
    $display("Test FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // Model and helpers

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      $display("[FAIL] %0t ns: %s expected 0x%0h got 0x%0h", $time, what, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic update_model(input logic [4:0] addr, input logic [7:0] data);
    case (addr)
      per_pkg::reg_pa:   m_pa = data;
      per_pkg::reg_pb:   m_pb = data;
      per_pkg::reg_mb:   m_mb = data;
      per_pkg::reg_mk:   m_mk = data;
      per_pkg::reg_tm0:  m_tm[7:0] = data;
      per_pkg::reg_tm1:  m_tm[11:8] = data[3:0];
      per_pkg::reg_ctrl: m_ie = data[0];
      per_pkg::reg_pend: m_pend = m_pend & ~data[3:0];
      default: ;
    endcase
  endtask

  // Each MB bit picks the pin when 1 and the output latch when 0
  function automatic logic [7:0] port_b_read(input logic [7:0] mb, input logic [7:0] pin,
                                             input logic [7:0] latch);
    logic [7:0] v;
    for (int i = 0; i < 8; i++) begin
      v[i] = mb[i] ? pin[i] : latch[i];
    end
    return v;
  endfunction

  function automatic logic [7:0] expect_read(input logic [4:0] addr);
    case (addr)
      per_pkg::reg_pa:   return m_pa;
      per_pkg::reg_pb:   return port_b_read(m_mb, pb_in, m_pb);
      per_pkg::reg_mb:   return m_mb;
      per_pkg::reg_mk:   return m_mk;
      per_pkg::reg_tm0:  return m_tm[7:0];
      per_pkg::reg_tm1:  return {4'h0, m_tm[11:8]};
      per_pkg::reg_ctrl: return {7'h00, m_ie};
      per_pkg::reg_pend: return {4'h0, m_pend};
      default:           return 8'h00;
    endcase
  endfunction

  function automatic logic [4:0] rw_addr(input int i);
    case (i)
      0:       return 5'(per_pkg::reg_pa);
      1:       return 5'(per_pkg::reg_mb);
      2:       return 5'(per_pkg::reg_mk);
      3:       return 5'(per_pkg::reg_tm0);
      4:       return 5'(per_pkg::reg_tm1);
      default: return 5'(per_pkg::reg_ctrl);
    endcase
  endfunction

  // Index 0 is the highest priority
  function automatic int lowest_index(input logic [3:0] m);
    for (int i = 0; i < 4; i++) begin
      if (m[i]) return i;
    end
    return -1;
  endfunction

  function automatic logic [7:0] vector_of(input int idx);
    case (idx)
      0:       return 8'h04;
      1:       return 8'h08;
      2:       return 8'h10;
      default: return 8'h20;
    endcase
  endfunction

  task automatic apply_reset();
    @(posedge CLK);
    reset   <= 1'b1;
    apb_req <= '0;
    irq_ack <= 1'b0;
    pb_in   <= 8'h00;
    int0    <= 1'b0;
    int1    <= 1'b0;
    int2    <= 1'b0;
    repeat (10) @(posedge CLK);
    reset  <= 1'b0;
    m_pa   = 8'h00;
    m_pb   = 8'h00;
    m_mb   = 8'hFF;
    m_mk   = 8'hFF;
    m_tm   = 12'hFFF;
    m_ie   = 1'b0;
    m_pend = 4'h0;
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [7:0] data);
    @(posedge CLK);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b1;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= data;
    @(posedge CLK);
    apb_req.penable <= 1'b1;
    @(posedge CLK);
    apb_req <= '0;
    update_model(addr, data);
  endtask

  task automatic read_reg(input logic [4:0] addr);
    @(posedge CLK);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b0;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= 8'h00;
    @(posedge CLK);
    apb_req.penable <= 1'b1;
    // Data valid in the access phase
    @(negedge CLK);
    rd_data = apb_rsp.prdata;
    rd_err  = apb_rsp.pslverr;
    check_eq("pready in the access phase", 1, apb_rsp.pready);
    @(posedge CLK);
    apb_req <= '0;
  endtask

  task automatic read_and_compare(input logic [4:0] addr, input string what);
    read_reg(addr);
    check_eq(what, expect_read(addr), rd_data);
    check_eq("pslverr on a mapped offset", 0, rd_err);
  endtask

  task automatic wait_for_req(input int max_cycles, output bit seen);
    seen = 1'b0;
    for (int i = 0; i < max_cycles && !seen; i++) begin
      @(negedge CLK);
      seen = irq.req;
    end
    if (!seen) begin
      $display("Interrupt request did not arrive within %0d cycles at %0t ns",
               max_cycles, $time);
      errors++;
      test_errors++;
    end
  endtask

  task automatic acknowledge();
    @(posedge CLK);
    irq_ack <= 1'b1;
    @(posedge CLK);
    irq_ack <= 1'b0;
    @(negedge CLK);
    check_eq("req drops after acknowledge", 0, irq.req);
  endtask

  task automatic set_src(input int idx, input logic v);
    if (idx == 2) int1 <= v;
    else int2 <= v;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("test %0d %s finished with %0d mismatches", tests_run, name, test_errors);
    test_errors = 0;
  endtask

  ////////////////////////////////////////
  // Tests

  task automatic test_registers();
    int         sel;
    logic [4:0] bad;
    apply_reset();
    @(negedge CLK);
    check_eq("req after reset", 0, irq.req);
    check_eq("pslverr after reset", 0, apb_rsp.pslverr);
    read_and_compare(per_pkg::reg_pend, "PEND after reset");
    repeat (20) begin
      sel = $urandom_range(5, 0);
      write_reg(rw_addr(sel), 8'($urandom));
      for (int j = 0; j < 6; j++) read_and_compare(rw_addr(j), "register read back");
    end
    bad = {3'($urandom), 2'($urandom_range(3, 1))};
    read_reg(bad);
    check_eq("pslverr on an unmapped offset", 1, rd_err);
  endtask

  task automatic test_port_b();
    apply_reset();
    repeat (10) begin
      write_reg(per_pkg::reg_mb, 8'($urandom));
      write_reg(per_pkg::reg_pb, 8'($urandom));
      write_reg(per_pkg::reg_pa, 8'($urandom));
      pb_in <= 8'($urandom);
      read_and_compare(per_pkg::reg_pb, "PB pin and latch mix");
      @(negedge CLK);
      check_eq("pb_oe", 8'(~m_mb), pb_oe);
      check_eq("pb_out", m_pb, pb_out);
      check_eq("pa_out", m_pa, pa_out);
    end
  endtask

  task automatic test_timer();
    int          r;
    int unsigned t0;
    int unsigned t1;
    bit          seen;
    r = $urandom_range(20, 1);
    apply_reset();
    write_reg(per_pkg::reg_mk, 8'hFD);
    write_reg(per_pkg::reg_tm0, 8'(r));
    write_reg(per_pkg::reg_tm1, 8'h00);
    // Restart and ie in one write
    write_reg(per_pkg::reg_ctrl, 8'h03);
    @(negedge CLK);
    t0 = cyc;
    wait_for_req(400, seen);
    t1 = cyc;
    check_eq("restart to INTT request", (r + 1) * 8 + 1, t1 - t0);
    check_eq("INTT vector", 8'h08, irq.vector);
    acknowledge();
    wait_for_req(400, seen);
    check_eq("underflow spacing", (r + 1) * 8, cyc - t1);
  endtask

  task automatic run_filter_case(input int idx, input bit rise);
    logic active;
    active = (idx == 2) ? 1'b1 : rise;
    apply_reset();
    if (!rise) write_reg(per_pkg::reg_mk, 8'hDF);
    set_src(idx, ~active);
    repeat (6 * tick_cycles) @(posedge CLK);
    write_reg(per_pkg::reg_pend, 8'h0F);
    read_and_compare(per_pkg::reg_pend, "PEND before pulse");
    // Two samples only is too short to pass
    @(posedge CLK);
    set_src(idx, active);
    repeat (2 * tick_cycles) @(posedge CLK);
    set_src(idx, ~active);
    repeat (6 * tick_cycles) @(posedge CLK);
    read_and_compare(per_pkg::reg_pend, "PEND after short pulse");
    @(posedge CLK);
    set_src(idx, active);
    repeat (5 * tick_cycles) @(posedge CLK);
    m_pend[idx] = 1'b1;
    read_and_compare(per_pkg::reg_pend, "PEND after held level");
    set_src(idx, ~active);
  endtask

  task automatic run_priority_case();
    logic [3:0] src;
    logic [3:0] msk;
    logic       ie;
    logic [3:0] enabled;
    int         first;
    int         hold;
    logic [7:0] vec;
    src  = 4'($urandom);
    msk  = 4'($urandom);
    ie   = 1'($urandom);
    hold = $urandom_range(10, 3);
    apply_reset();
    @(posedge CLK);
    int0 <= src[0];
    int1 <= src[2];
    int2 <= src[3];
    if (src[1]) begin
      // Short period for one underflow and then park the timer far away
      write_reg(per_pkg::reg_tm0, 8'h02);
      write_reg(per_pkg::reg_tm1, 8'h00);
      write_reg(per_pkg::reg_ctrl, 8'h02);
      repeat (40) @(posedge CLK);
      write_reg(per_pkg::reg_tm0, 8'hFF);
      write_reg(per_pkg::reg_tm1, 8'h0F);
      write_reg(per_pkg::reg_ctrl, 8'h02);
    end
    repeat (80) @(posedge CLK);
    m_pend = src;
    read_and_compare(per_pkg::reg_pend, "PEND with sources raised");
    write_reg(per_pkg::reg_mk, {4'hF, msk});
    write_reg(per_pkg::reg_ctrl, {7'h00, ie});
    enabled = ie ? (src & ~msk) : 4'h0;
    repeat (3) @(negedge CLK);
    check_eq("req against enabled pending", |enabled, irq.req);
    if (enabled != 4'h0) begin
      first = lowest_index(enabled);
      vec   = vector_of(first);
      repeat (hold) begin
        check_eq("vector under back-pressure", vec, irq.vector);
        check_eq("req under back-pressure", 1, irq.req);
        @(negedge CLK);
      end
      acknowledge();
      m_pend[first] = 1'b0;
      read_and_compare(per_pkg::reg_pend, "PEND after acknowledge");
    end
    write_reg(per_pkg::reg_pend, 8'h0F);
    read_and_compare(per_pkg::reg_pend, "PEND after host clear");
  endtask

  ////////////////////////////////////////
  // Main sequence

  initial begin
    void'($urandom(35064));
    reset       = 1'b1;
    apb_req     = '0;
    pb_in       = 8'h00;
    int0        = 1'b0;
    int1        = 1'b0;
    int2        = 1'b0;
    irq_ack     = 1'b0;
    cyc         = 0;
    errors      = 0;
    test_errors = 0;
    tests_run   = 0;
    checks      = 0;

    test_registers();
    finish_test("registers");
    test_port_b();
    finish_test("port_b");
    test_timer();
    finish_test("timer");
    run_filter_case(2, 1'b1);
    run_filter_case(3, 1'b1);
    run_filter_case(3, 1'b0);
    finish_test("int_filter");
    repeat (8) run_priority_case();
    finish_test("priority");

    $display("%0d tests, %0d checks, %0d failures", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
per_pkg.sv
irq_pkg.sv
per_regs.sv
irq_sampler.sv
irq_pending.sv
irq_arbiter.sv
event_timer.sv
per_top.sv
tb_per_top.sv
